// ==== hw/mips_alu_pkg.sv ====
package mips_alu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  regimm_t;

	// Codes follow the 5-bit ALU control word where one exists
	typedef enum logic [4:0] {
		OP_AND     = 5'b00000,
		OP_OR      = 5'b00001,
		OP_XOR     = 5'b00010,
		OP_ADDU    = 5'b00011,
		OP_SUBU    = 5'b00100,
		OP_SLTU    = 5'b00101,
		OP_SLT     = 5'b00110,
		OP_MULTU   = 5'b00111,
		OP_MULT    = 5'b01000,
		OP_SLL     = 5'b01001,
		OP_SLLV    = 5'b01010,
		OP_SRA     = 5'b01011,
		OP_SRL     = 5'b01100,
		OP_SRAV    = 5'b01101,
		OP_SRLV    = 5'b01110,
		OP_LUI     = 5'b01111,
		OP_MFHI    = 5'b10010,
		OP_MFLO    = 5'b10011,
		OP_BLTZ    = 5'b10100,
		OP_BGTZ    = 5'b10110,
		OP_BLEZ    = 5'b10111,
		OP_BNE     = 5'b11000,
		OP_NOR     = 5'b11001,
		OP_BEQ     = 5'b11010,
		OP_BGEZ    = 5'b11011,
		OP_ILLEGAL = 5'b11111
	} alu_op_t;

	localparam opcode_t OPC_SPECIAL = 6'h00;
	localparam opcode_t OPC_REGIMM  = 6'h01;
	localparam opcode_t OPC_BEQ     = 6'h04;
	localparam opcode_t OPC_BNE     = 6'h05;
	localparam opcode_t OPC_BLEZ    = 6'h06;
	localparam opcode_t OPC_BGTZ    = 6'h07;
	localparam opcode_t OPC_ADDIU   = 6'h09;
	localparam opcode_t OPC_SLTI    = 6'h0a;
	localparam opcode_t OPC_SLTIU   = 6'h0b;
	localparam opcode_t OPC_ANDI    = 6'h0c;
	localparam opcode_t OPC_ORI     = 6'h0d;
	localparam opcode_t OPC_XORI    = 6'h0e;
	localparam opcode_t OPC_LUI     = 6'h0f;

	localparam funct_t FN_SLL   = 6'h00;
	localparam funct_t FN_SRL   = 6'h02;
	localparam funct_t FN_SRA   = 6'h03;
	localparam funct_t FN_SLLV  = 6'h04;
	localparam funct_t FN_SRLV  = 6'h06;
	localparam funct_t FN_SRAV  = 6'h07;
	localparam funct_t FN_MFHI  = 6'h10;
	localparam funct_t FN_MFLO  = 6'h12;
	localparam funct_t FN_MULT  = 6'h18;
	localparam funct_t FN_MULTU = 6'h19;
	localparam funct_t FN_ADDU  = 6'h21;
	localparam funct_t FN_SUBU  = 6'h23;
	localparam funct_t FN_AND   = 6'h24;
	localparam funct_t FN_OR    = 6'h25;
	localparam funct_t FN_XOR   = 6'h26;
	localparam funct_t FN_NOR   = 6'h27;
	localparam funct_t FN_SLT   = 6'h2a;
	localparam funct_t FN_SLTU  = 6'h2b;

	localparam regimm_t RT_BLTZ = 5'h00;
	localparam regimm_t RT_BGEZ = 5'h01;

endpackage

// ==== hw/alu_op_decoder.sv ====
`timescale 1ns/10ps

module alu_op_decoder (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	input  mips_alu_pkg::word_t   instr,
	input  mips_alu_pkg::word_t   a,
	input  mips_alu_pkg::word_t   b,
	output logic                  d_valid,
	output mips_alu_pkg::alu_op_t d_op,
	output mips_alu_pkg::word_t   d_a,
	output mips_alu_pkg::word_t   d_b,
	output mips_alu_pkg::shamt_t  d_shamt
);

	mips_alu_pkg::opcode_t opcode;
	mips_alu_pkg::funct_t  funct;
	mips_alu_pkg::regimm_t rt;
	mips_alu_pkg::alu_op_t dec_op;

	assign opcode = instr[31:26];
	assign rt     = instr[20:16];
	assign funct  = instr[5:0];

	always_comb begin
		dec_op = mips_alu_pkg::OP_ILLEGAL;
		case (opcode)
			mips_alu_pkg::OPC_SPECIAL: begin
				case (funct)
					mips_alu_pkg::FN_SLL:   dec_op = mips_alu_pkg::OP_SLL;
					mips_alu_pkg::FN_SRL:   dec_op = mips_alu_pkg::OP_SRL;
					mips_alu_pkg::FN_SRA:   dec_op = mips_alu_pkg::OP_SRA;
					mips_alu_pkg::FN_SLLV:  dec_op = mips_alu_pkg::OP_SLLV;
					mips_alu_pkg::FN_SRLV:  dec_op = mips_alu_pkg::OP_SRLV;
					mips_alu_pkg::FN_SRAV:  dec_op = mips_alu_pkg::OP_SRAV;
					mips_alu_pkg::FN_MFHI:  dec_op = mips_alu_pkg::OP_MFHI;
					mips_alu_pkg::FN_MFLO:  dec_op = mips_alu_pkg::OP_MFLO;
					mips_alu_pkg::FN_MULT:  dec_op = mips_alu_pkg::OP_MULT;
					mips_alu_pkg::FN_MULTU: dec_op = mips_alu_pkg::OP_MULTU;
					mips_alu_pkg::FN_ADDU:  dec_op = mips_alu_pkg::OP_ADDU;
					mips_alu_pkg::FN_SUBU:  dec_op = mips_alu_pkg::OP_SUBU;
					mips_alu_pkg::FN_AND:   dec_op = mips_alu_pkg::OP_AND;
					mips_alu_pkg::FN_OR:    dec_op = mips_alu_pkg::OP_OR;
					mips_alu_pkg::FN_XOR:   dec_op = mips_alu_pkg::OP_XOR;
					mips_alu_pkg::FN_NOR:   dec_op = mips_alu_pkg::OP_NOR;
					mips_alu_pkg::FN_SLT:   dec_op = mips_alu_pkg::OP_SLT;
					mips_alu_pkg::FN_SLTU:  dec_op = mips_alu_pkg::OP_SLTU;
					default:                dec_op = mips_alu_pkg::OP_ILLEGAL;
				endcase
			end
			mips_alu_pkg::OPC_REGIMM: begin
				if (rt == mips_alu_pkg::RT_BLTZ)
					dec_op = mips_alu_pkg::OP_BLTZ;
				else if (rt == mips_alu_pkg::RT_BGEZ)
					dec_op = mips_alu_pkg::OP_BGEZ;
			end
			mips_alu_pkg::OPC_BEQ:   dec_op = mips_alu_pkg::OP_BEQ;
			mips_alu_pkg::OPC_BNE:   dec_op = mips_alu_pkg::OP_BNE;
			mips_alu_pkg::OPC_BLEZ:  dec_op = mips_alu_pkg::OP_BLEZ;
			mips_alu_pkg::OPC_BGTZ:  dec_op = mips_alu_pkg::OP_BGTZ;
			mips_alu_pkg::OPC_ADDIU: dec_op = mips_alu_pkg::OP_ADDU;	// Immediate already in b
			mips_alu_pkg::OPC_SLTI:  dec_op = mips_alu_pkg::OP_SLT;
			mips_alu_pkg::OPC_SLTIU: dec_op = mips_alu_pkg::OP_SLTU;
			mips_alu_pkg::OPC_ANDI:  dec_op = mips_alu_pkg::OP_AND;
			mips_alu_pkg::OPC_ORI:   dec_op = mips_alu_pkg::OP_OR;
			mips_alu_pkg::OPC_XORI:  dec_op = mips_alu_pkg::OP_XOR;
			mips_alu_pkg::OPC_LUI:   dec_op = mips_alu_pkg::OP_LUI;
			default:                 dec_op = mips_alu_pkg::OP_ILLEGAL;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			d_valid <= 1'b0;
		else
			d_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		d_op    <= dec_op;
		d_a     <= a;
		d_b     <= b;
		d_shamt <= instr[10:6];	// Fixed shift amount field
	end

endmodule

// ==== hw/alu_stage.sv ====
`timescale 1ns/10ps

module alu_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  d_valid,
	input  mips_alu_pkg::alu_op_t d_op,
	input  mips_alu_pkg::word_t   d_a,
	input  mips_alu_pkg::word_t   d_b,
	input  mips_alu_pkg::shamt_t  d_shamt,
	output logic                  x_valid,
	output mips_alu_pkg::alu_op_t x_op,
	output mips_alu_pkg::word_t   x_result,
	output logic                  x_branch_taken
);

	mips_alu_pkg::word_t   alu_res;
	logic                  branch;
	mips_alu_pkg::shamt_t  var_sh;

	logic                  s1_valid;
	mips_alu_pkg::alu_op_t s1_op;
	mips_alu_pkg::word_t   s1_result;
	logic                  s1_branch;

	assign var_sh = d_a[4:0];	// Variable shifts take rs[4:0]

	always_comb begin
		alu_res = '0;
		branch  = 1'b0;
		case (d_op)
			mips_alu_pkg::OP_AND:  alu_res = d_a & d_b;
			mips_alu_pkg::OP_OR:   alu_res = d_a | d_b;
			mips_alu_pkg::OP_XOR:  alu_res = d_a ^ d_b;
			mips_alu_pkg::OP_NOR:  alu_res = ~(d_a | d_b);
			mips_alu_pkg::OP_ADDU: alu_res = d_a + d_b;
			mips_alu_pkg::OP_SUBU: alu_res = d_a - d_b;
			mips_alu_pkg::OP_SLT:  alu_res = {31'b0, $signed(d_a) < $signed(d_b)};
			mips_alu_pkg::OP_SLTU: alu_res = {31'b0, d_a < d_b};
			mips_alu_pkg::OP_SLL:  alu_res = d_b << d_shamt;
			mips_alu_pkg::OP_SRL:  alu_res = d_b >> d_shamt;
			mips_alu_pkg::OP_SRA:  alu_res = $signed(d_b) >>> d_shamt;	// Sign bits fill in
			mips_alu_pkg::OP_SLLV: alu_res = d_b << var_sh;
			mips_alu_pkg::OP_SRLV: alu_res = d_b >> var_sh;
			mips_alu_pkg::OP_SRAV: alu_res = $signed(d_b) >>> var_sh;
			mips_alu_pkg::OP_LUI:  alu_res = d_b << 16;
			mips_alu_pkg::OP_BEQ:  branch = (d_a == d_b);
			mips_alu_pkg::OP_BNE:  branch = (d_a != d_b);
			mips_alu_pkg::OP_BLTZ: branch = $signed(d_a) < 0;
			mips_alu_pkg::OP_BGEZ: branch = $signed(d_a) >= 0;
			mips_alu_pkg::OP_BLEZ: branch = $signed(d_a) <= 0;
			mips_alu_pkg::OP_BGTZ: branch = $signed(d_a) > 0;
			default: begin
				alu_res = '0;	// Multiply, move from HI/LO, illegal
				branch  = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			x_valid  <= 1'b0;
		end else begin
			s1_valid <= d_valid;
			x_valid  <= s1_valid;
		end
	end

	// Second register only delays to line up with the multiplier
	always_ff @(posedge clk) begin
		s1_op          <= d_op;
		s1_result      <= alu_res;
		s1_branch      <= branch;
		x_op           <= s1_op;
		x_result       <= s1_result;
		x_branch_taken <= s1_branch;
	end

endmodule

// ==== hw/hilo_multiplier.sv ====
`timescale 1ns/10ps

module hilo_multiplier (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  d_valid,
	input  mips_alu_pkg::alu_op_t d_op,
	input  mips_alu_pkg::word_t   d_a,
	input  mips_alu_pkg::word_t   d_b,
	output mips_alu_pkg::word_t   m_result
);

	logic                  is_signed;
	logic                  is_mul;
	mips_alu_pkg::word_t   mag_a;
	mips_alu_pkg::word_t   mag_b;
	logic [63:0]           mag_prod;

	logic [63:0]           p1_prod;
	logic                  p1_neg;
	logic                  p1_mul;
	mips_alu_pkg::alu_op_t p1_op;

	mips_alu_pkg::word_t   hi;
	mips_alu_pkg::word_t   lo;

	assign is_signed = (d_op == mips_alu_pkg::OP_MULT);
	assign is_mul    = is_signed || (d_op == mips_alu_pkg::OP_MULTU);

	// Work on magnitudes and fix the sign afterwards
	assign mag_a    = (is_signed && d_a[31]) ? (~d_a + 32'd1) : d_a;
	assign mag_b    = (is_signed && d_b[31]) ? (~d_b + 32'd1) : d_b;
	assign mag_prod = {32'b0, mag_a} * {32'b0, mag_b};

	always_ff @(posedge clk) begin
		if (reset)
			p1_mul <= 1'b0;
		else
			p1_mul <= d_valid && is_mul;
	end

	always_ff @(posedge clk) begin
		p1_prod <= mag_prod;
		p1_neg  <= is_signed && (d_a[31] ^ d_b[31]);
		p1_op   <= d_op;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else if (p1_mul) begin
			if (p1_neg)
				{hi, lo} <= ~p1_prod + 64'd1;	// Two's complement of the product
			else
				{hi, lo} <= p1_prod;
		end
	end

	// Earlier multiply has already landed in HI/LO here
	always_ff @(posedge clk) begin
		if (p1_op == mips_alu_pkg::OP_MFHI)
			m_result <= hi;
		else
			m_result <= lo;
	end

endmodule

// ==== hw/writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  x_valid,
	input  mips_alu_pkg::alu_op_t x_op,
	input  mips_alu_pkg::word_t   x_result,
	input  logic                  x_branch_taken,
	input  mips_alu_pkg::word_t   m_result,
	output logic                  out_valid,
	output mips_alu_pkg::word_t   result,
	output logic                  zero,
	output logic                  branch_taken,
	output logic                  reg_write,
	output logic                  illegal
);

	mips_alu_pkg::word_t sel_result;
	logic                writes;

	assign sel_result = (x_op == mips_alu_pkg::OP_MFHI || x_op == mips_alu_pkg::OP_MFLO) ?
		m_result : x_result;

	always_comb begin
		case (x_op)
			mips_alu_pkg::OP_BEQ, mips_alu_pkg::OP_BNE,
			mips_alu_pkg::OP_BLTZ, mips_alu_pkg::OP_BGEZ,
			mips_alu_pkg::OP_BLEZ, mips_alu_pkg::OP_BGTZ: writes = 1'b0;
			mips_alu_pkg::OP_MULT, mips_alu_pkg::OP_MULTU: writes = 1'b0;	// Only HI/LO change
			mips_alu_pkg::OP_ILLEGAL: writes = 1'b0;
			default: writes = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			branch_taken <= 1'b0;
			reg_write    <= 1'b0;
			illegal      <= 1'b0;
		end else begin
			out_valid    <= x_valid;
			branch_taken <= x_valid && x_branch_taken;
			reg_write    <= x_valid && writes;
			illegal      <= x_valid && (x_op == mips_alu_pkg::OP_ILLEGAL);
		end
	end

	always_ff @(posedge clk) begin
		result <= x_valid ? sel_result : '0;
		zero   <= x_valid && (sel_result == '0);
	end

endmodule

// ==== hw/mips_execute_top.sv ====
`timescale 1ns/10ps

module mips_execute_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	input  mips_alu_pkg::word_t instr,
	input  mips_alu_pkg::word_t a,
	input  mips_alu_pkg::word_t b,
	output logic                out_valid,
	output mips_alu_pkg::word_t result,
	output logic                zero,
	output logic                branch_taken,
	output logic                reg_write,
	output logic                illegal
);

	logic                  d_valid;
	mips_alu_pkg::alu_op_t d_op;
	mips_alu_pkg::word_t   d_a;
	mips_alu_pkg::word_t   d_b;
	mips_alu_pkg::shamt_t  d_shamt;

	logic                  x_valid;
	mips_alu_pkg::alu_op_t x_op;
	mips_alu_pkg::word_t   x_result;
	logic                  x_branch_taken;
	mips_alu_pkg::word_t   m_result;

	alu_op_decoder u_decoder (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.instr    (instr),
		.a        (a),
		.b        (b),
		.d_valid  (d_valid),
		.d_op     (d_op),
		.d_a      (d_a),
		.d_b      (d_b),
		.d_shamt  (d_shamt)
	);

	alu_stage u_alu (
		.clk            (clk),
		.reset          (reset),
		.d_valid        (d_valid),
		.d_op           (d_op),
		.d_a            (d_a),
		.d_b            (d_b),
		.d_shamt        (d_shamt),
		.x_valid        (x_valid),
		.x_op           (x_op),
		.x_result       (x_result),
		.x_branch_taken (x_branch_taken)
	);

	hilo_multiplier u_mult (
		.clk      (clk),
		.reset    (reset),
		.d_valid  (d_valid),
		.d_op     (d_op),
		.d_a      (d_a),
		.d_b      (d_b),
		.m_result (m_result)
	);

	writeback_stage u_writeback (
		.clk            (clk),
		.reset          (reset),
		.x_valid        (x_valid),
		.x_op           (x_op),
		.x_result       (x_result),
		.x_branch_taken (x_branch_taken),
		.m_result       (m_result),
		.out_valid      (out_valid),
		.result         (result),
		.zero           (zero),
		.branch_taken   (branch_taken),
		.reg_write      (reg_write),
		.illegal        (illegal)
	);

endmodule

// ==== tb/tb_mips_execute.sv ====
`timescale 1ns/10ps

module tb_mips_execute;

	localparam int N_RAND = 200;

	typedef struct {
		logic                valid;
		mips_alu_pkg::word_t instr;
		mips_alu_pkg::word_t a;
		mips_alu_pkg::word_t b;
		mips_alu_pkg::word_t res;
		logic [3:0]          flags;	// {zero, branch_taken, reg_write, illegal}
		int                  issued;
	} entry_t;

	logic                clk;
	logic                reset;
	logic                in_valid;
	mips_alu_pkg::word_t instr;
	mips_alu_pkg::word_t a;
	mips_alu_pkg::word_t b;
	logic                out_valid;
	mips_alu_pkg::word_t result;
	logic                zero;
	logic                branch_taken;
	logic                reg_write;
	logic                illegal;

	entry_t      rows[$];
	entry_t      exp_q[$];	// Issued and not yet retired
	int          cyc;
	int          errors;
	logic [31:0] seed;

	mips_execute_top UUT (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.instr        (instr),
		.a            (a),
		.b            (b),
		.out_valid    (out_valid),
		.result       (result),
		.zero         (zero),
		.branch_taken (branch_taken),
		.reg_write    (reg_write),
		.illegal      (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	function automatic mips_alu_pkg::word_t r_op(input mips_alu_pkg::funct_t fn);
		return {6'h00, 20'h0, fn};
	endfunction

	function automatic mips_alu_pkg::word_t sh_op(input mips_alu_pkg::funct_t fn,
			input mips_alu_pkg::shamt_t sh);
		return {6'h00, 15'h0, sh, fn};
	endfunction

	function automatic mips_alu_pkg::word_t i_op(input mips_alu_pkg::opcode_t opc);
		return {opc, 26'h0};
	endfunction

	function automatic mips_alu_pkg::word_t b_op(input mips_alu_pkg::regimm_t rt);
		return {mips_alu_pkg::OPC_REGIMM, 5'h0, rt, 16'h0};
	endfunction

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// Expected result of an R-type operation
	function automatic mips_alu_pkg::word_t model_result(input mips_alu_pkg::funct_t fn,
			input mips_alu_pkg::shamt_t sh, input mips_alu_pkg::word_t x,
			input mips_alu_pkg::word_t y);
		mips_alu_pkg::shamt_t vs;
		vs = x[4:0];
		case (fn)
			mips_alu_pkg::FN_ADDU: return x + y;
			mips_alu_pkg::FN_SUBU: return x - y;
			mips_alu_pkg::FN_AND:  return x & y;
			mips_alu_pkg::FN_OR:   return x | y;
			mips_alu_pkg::FN_XOR:  return x ^ y;
			mips_alu_pkg::FN_NOR:  return ~(x | y);
			mips_alu_pkg::FN_SLT:  return ((x ^ 32'h80000000) < (y ^ 32'h80000000)) ? 1 : 0;
			mips_alu_pkg::FN_SLTU: return (x < y) ? 1 : 0;
			mips_alu_pkg::FN_SLL:  return y << sh;
			mips_alu_pkg::FN_SRL:  return y >> sh;
			mips_alu_pkg::FN_SRA:  return (y >> sh) | (y[31] ? ~(32'hffffffff >> sh) : 32'h0);
			mips_alu_pkg::FN_SLLV: return y << vs;
			mips_alu_pkg::FN_SRLV: return y >> vs;
			mips_alu_pkg::FN_SRAV: return (y >> vs) | (y[31] ? ~(32'hffffffff >> vs) : 32'h0);
			default:               return 32'h0;
		endcase
	endfunction

	task automatic check_word(input mips_alu_pkg::word_t got, input mips_alu_pkg::word_t want,
			input string what);
		if (got !== want) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
			$display("Checks failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		if (got !== want) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
			$display("Checks failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic add_row(input mips_alu_pkg::word_t iw, input mips_alu_pkg::word_t av,
			input mips_alu_pkg::word_t bv, input mips_alu_pkg::word_t res, input logic [3:0] flags);
		rows.push_back('{1'b1, iw, av, bv, res, flags, 0});
	endtask

	task automatic add_bubble();
		rows.push_back('{1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 4'b0000, 0});
	endtask

	task automatic issue(input entry_t e);
		in_valid <= e.valid;
		instr    <= e.instr;
		a        <= e.a;
		b        <= e.b;
		if (e.valid) begin
			e.issued = cyc + 1;
			exp_q.push_back(e);
		end
	endtask

	task automatic build_table();
		add_row(r_op(mips_alu_pkg::FN_MFHI), 0, 0, 0, 4'b1010);	// HI cleared by reset
		add_row(r_op(mips_alu_pkg::FN_ADDU), 5, 7, 12, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_SUBU), 5, 7, 32'hfffffffe, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_SUBU), 9, 9, 0, 4'b1010);
		add_bubble();
		add_row(r_op(mips_alu_pkg::FN_AND), 32'hf0f000ff, 32'h0ff00f0f, 32'h00f0000f, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_OR), 32'h1230, 32'h34, 32'h1234, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_XOR), 32'hffff0000, 32'h0f0f0f0f, 32'hf0f00f0f, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_NOR), 0, 0, 32'hffffffff, 4'b0010);
		add_row(i_op(mips_alu_pkg::OPC_ADDIU), 10, 32'hfffffffd, 7, 4'b0010);
		add_row(i_op(mips_alu_pkg::OPC_ANDI), 32'h12345678, 32'hffff, 32'h5678, 4'b0010);
		add_row(i_op(mips_alu_pkg::OPC_ORI), 32'h12340ff0, 32'h5678, 32'h12345ff8, 4'b0010);
		add_row(i_op(mips_alu_pkg::OPC_XORI), 32'hff, 32'h0f, 32'hf0, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_SLT), 32'hffffffff, 1, 1, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_SLTU), 32'hffffffff, 1, 0, 4'b1010);
		add_row(i_op(mips_alu_pkg::OPC_SLTI), 32'hfffffffb, 2, 1, 4'b0010);
		add_row(i_op(mips_alu_pkg::OPC_SLTIU), 3, 32'hffffffff, 1, 4'b0010);
		add_row(i_op(mips_alu_pkg::OPC_LUI), 0, 32'habcd, 32'habcd0000, 4'b0010);
		add_bubble();
		add_bubble();
		add_row(sh_op(mips_alu_pkg::FN_SLL, 5'd31), 0, 1, 32'h80000000, 4'b0010);
		add_row(sh_op(mips_alu_pkg::FN_SRL, 5'd0), 0, 32'h80000000, 32'h80000000, 4'b0010);
		add_row(sh_op(mips_alu_pkg::FN_SRA, 5'd4), 0, 32'h80000000, 32'hf8000000, 4'b0010);
		add_row(sh_op(mips_alu_pkg::FN_SRA, 5'd31), 0, 32'hf0000000, 32'hffffffff, 4'b0010);
		add_row(sh_op(mips_alu_pkg::FN_SRL, 5'd28), 0, 32'hf0000000, 32'hf, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_SLLV), 4, 3, 32'h30, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_SRLV), 32'h24, 32'h100, 32'h10, 4'b0010);	// Only a[4:0]
		add_row(r_op(mips_alu_pkg::FN_SRAV), 32'h3f, 32'h80000000, 32'hffffffff, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_MULT), 32'hfffffffd, 7, 0, 4'b1000);	// -3 * 7
		add_row(r_op(mips_alu_pkg::FN_MFHI), 0, 0, 32'hffffffff, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_MFLO), 0, 0, 32'hffffffeb, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_MULTU), 32'hffffffff, 2, 0, 4'b1000);
		add_row(r_op(mips_alu_pkg::FN_MFLO), 0, 0, 32'hfffffffe, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_MFHI), 0, 0, 1, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_MULT), 6, 32'hfffffffe, 0, 4'b1000);
		add_row(r_op(mips_alu_pkg::FN_MFLO), 0, 0, 32'hfffffff4, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_MULTU), 6, 32'hfffffffe, 0, 4'b1000);
		add_row(r_op(mips_alu_pkg::FN_MFHI), 0, 0, 5, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_MULT), 32'h80000000, 32'h80000000, 0, 4'b1000);
		add_row(r_op(mips_alu_pkg::FN_MFHI), 0, 0, 32'h40000000, 4'b0010);
		add_row(r_op(mips_alu_pkg::FN_MFLO), 0, 0, 0, 4'b1010);
		add_row(i_op(mips_alu_pkg::OPC_BEQ), 5, 5, 0, 4'b1100);
		add_row(i_op(mips_alu_pkg::OPC_BNE), 5, 5, 0, 4'b1000);
		add_row(i_op(mips_alu_pkg::OPC_BNE), 5, 6, 0, 4'b1100);
		add_row(b_op(mips_alu_pkg::RT_BLTZ), 32'hffffffff, 0, 0, 4'b1100);
		add_row(b_op(mips_alu_pkg::RT_BLTZ), 0, 0, 0, 4'b1000);
		add_row(b_op(mips_alu_pkg::RT_BGEZ), 0, 0, 0, 4'b1100);
		add_row(b_op(mips_alu_pkg::RT_BGEZ), 32'h80000000, 0, 0, 4'b1000);
		add_row(i_op(mips_alu_pkg::OPC_BLEZ), 0, 0, 0, 4'b1100);
		add_row(i_op(mips_alu_pkg::OPC_BLEZ), 7, 0, 0, 4'b1000);
		add_row(i_op(mips_alu_pkg::OPC_BGTZ), 32'h80000000, 0, 0, 4'b1000);
		add_row(i_op(mips_alu_pkg::OPC_BGTZ), 1, 0, 0, 4'b1100);
		add_row(i_op(6'h02), 1, 2, 0, 4'b1001);	// Jump is not handled here
		add_row(r_op(6'h1a), 8, 2, 0, 4'b1001);	// DIV
		add_row(b_op(5'h10), 32'hffffffff, 0, 0, 4'b1001);	// BLTZAL
		add_bubble();
		add_row(r_op(mips_alu_pkg::FN_ADDU), 32'hffffffff, 1, 0, 4'b1010);
	endtask

	// Retire in issue order, exactly 4 cycles after the issuing edge
	initial begin
		entry_t e;
		forever begin
			@(negedge clk);
			if (!reset && out_valid) begin
				if (exp_q.size() == 0) begin
					$display("Result appeared at %0t with no instruction in flight", $time);
					$display("Checks failed");
					$fatal(1, "unexpected output");
				end else begin
					e = exp_q.pop_front();
					if (cyc - e.issued != 4) begin
						errors++;
						$display("Mismatch at %0t: instr %h took %0d cycles, expected 4",
							$time, e.instr, cyc - e.issued);
						$display("Checks failed");
						$fatal(1, "stopped at first error");
					end else begin
						check_word(result, e.res, "result");
						check_bit(zero, e.flags[3], "zero");
						check_bit(branch_taken, e.flags[2], "branch_taken");
						check_bit(reg_write, e.flags[1], "reg_write");
						check_bit(illegal, e.flags[0], "illegal");
					end
				end
			end else if (!reset && exp_q.size() > 0 && cyc - exp_q[0].issued >= 4) begin
				$display("No result at %0t for instr %h issued 4 cycles earlier",
					$time, exp_q[0].instr);
				$display("Checks failed");
				$fatal(1, "missing output");
			end
		end
	end

	initial begin
		mips_alu_pkg::funct_t rand_fn[14];
		mips_alu_pkg::funct_t fn;
		mips_alu_pkg::shamt_t sh;
		logic [31:0]          r;
		entry_t               row;
		reset    = 1'b1;
		in_valid = 1'b0;
		instr    = '0;
		a        = '0;
		b        = '0;
		cyc      = 0;
		errors   = 0;
		seed     = 32'he4cd;
		build_table();
		rand_fn = '{mips_alu_pkg::FN_ADDU, mips_alu_pkg::FN_SUBU, mips_alu_pkg::FN_AND,
			mips_alu_pkg::FN_OR, mips_alu_pkg::FN_XOR, mips_alu_pkg::FN_NOR,
			mips_alu_pkg::FN_SLT, mips_alu_pkg::FN_SLTU, mips_alu_pkg::FN_SLL,
			mips_alu_pkg::FN_SRL, mips_alu_pkg::FN_SRA, mips_alu_pkg::FN_SLLV,
			mips_alu_pkg::FN_SRLV, mips_alu_pkg::FN_SRAV};
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_bit(out_valid, 1'b0, "out_valid after reset");
		check_bit(reg_write, 1'b0, "reg_write after reset");
		check_bit(branch_taken, 1'b0, "branch_taken after reset");
		check_bit(illegal, 1'b0, "illegal after reset");
		foreach (rows[i]) begin
			@(posedge clk);
			issue(rows[i]);
		end
		for (int i = 0; i < N_RAND; i++) begin
			r         = next_random();
			fn        = rand_fn[r[27:16] % 14];
			sh        = r[12:8];
			row.valid = (r[31:29] != 3'd0);	// About one bubble in eight
			row.instr = sh_op(fn, sh);
			row.a     = next_random();
			row.b     = next_random();
			row.res   = model_result(fn, sh, row.a, row.b);
			row.flags = {row.res == 32'h0, 1'b0, 1'b1, 1'b0};
			row.issued = 0;
			@(posedge clk);
			issue(row);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (exp_q.size() > 0)
			@(posedge clk);
		@(negedge clk);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		int limit;
		#1;
		limit = (rows.size() + N_RAND + 20) * 4;
		#(limit);
		$display("Timeout: the run did not finish within %0d ns", limit);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== files.f ====
hw/mips_alu_pkg.sv
hw/alu_op_decoder.sv
hw/alu_stage.sv
hw/hilo_multiplier.sv
hw/writeback_stage.sv
hw/mips_execute_top.sv
tb/tb_mips_execute.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mips_execute -f files.f \
	--Mdir obj_dir -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0
